/* include/afifo_cfg.svh */
`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

// ------------------------------------------------------------
// fifo geometry.
// ------------------------------------------------------------

`define AFIFO_DATA_WIDTH 8    // bits per word.
`define AFIFO_DEPTH      16   // entries, power of two only.
`define AFIFO_ADDR_WIDTH 4    // log2 of the depth.

// ------------------------------------------------------------
// flag thresholds, in words.
// ------------------------------------------------------------

// afull is set at or above this write-side fill.
`define AFIFO_AFULL      14
// aempty is set at or below this read-side fill.
`define AFIFO_AEMPTY     2

`endif

/* rtl/afifo_pkg.sv */
`include "afifo_cfg.svh"

package afifo_pkg;

  // one data word.
  typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;

  // ram address, wrap bit stripped.
  typedef logic [`AFIFO_ADDR_WIDTH-1:0] addr_t;

  // pointer or fill count with wrap bit on top, binary or gray.
  typedef logic [`AFIFO_ADDR_WIDTH:0] ptr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

endpackage

/* rtl/afifo_ram.sv */
`timescale 1ns/1ns

`include "afifo_cfg.svh"

module afifo_ram import afifo_pkg::*; (
  input  logic  wr_clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  rd_en,
  input  addr_t rd_addr,
  output data_t rd_data
);

  data_t mem [`AFIFO_DEPTH];

  // ------------------------------------------------------------
  // write port.
  // ------------------------------------------------------------
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------------------------------------
  // registered read port.
  // ------------------------------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];  // holds last word when idle.
    end
  end

endmodule

/* rtl/afifo_ptr_sync.sv */
`timescale 1ns/1ns

module afifo_ptr_sync import afifo_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  ptr_t gray_in,
  output ptr_t bin_out
);

  ptr_t sync_q1;  // may go metastable.
  ptr_t sync_q2;

  // ------------------------------------------------------------
  // two flops in the destination clock.
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // gray to binary, each bit is the xor of itself and all above it.
  always_comb begin
    for (int i = 0; i < $bits(ptr_t); i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

endmodule

/* rtl/afifo_wr_ctrl.sv */
`timescale 1ns/1ns

`include "afifo_cfg.svh"

module afifo_wr_ctrl import afifo_pkg::*; (
  input  logic      wr_clk,
  input  logic      wr_rst_n,
  input  logic      wr_en,
  input  ptr_t      rd_ptr_sync,
  output logic      ram_wr_en,
  output addr_t     wr_addr,
  output ptr_t      wr_ptr_gray,
  output wr_flags_t wr_flags
);

  ptr_t wr_ptr;
  ptr_t wr_ptr_nxt;
  ptr_t wr_gray_nxt;
  ptr_t fill_nxt;
  logic wr_ok;

  // ------------------------------------------------------------
  // request qualification and next pointer.
  // ------------------------------------------------------------
  assign wr_ok       = wr_en & ~wr_flags.full;  // writes while full are dropped.
  assign wr_ptr_nxt  = wr_ptr + ptr_t'(wr_ok);
  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;

  // pessimistic fill, the read pointer seen here lags behind.
  assign fill_nxt = wr_ptr_nxt - rd_ptr_sync;

  assign ram_wr_en = wr_ok;
  assign wr_addr   = wr_ptr[`AFIFO_ADDR_WIDTH-1:0];

  // ------------------------------------------------------------
  // pointer registers.
  // ------------------------------------------------------------
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;  // registered, so glitch free across domains.
    end
  end

  // ------------------------------------------------------------
  // flags.
  // ------------------------------------------------------------
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_flags.full  <= 1'b0;
      wr_flags.afull <= 1'b0;
    end else begin
      wr_flags.full  <= (fill_nxt == ptr_t'(`AFIFO_DEPTH));
      wr_flags.afull <= (fill_nxt >= ptr_t'(`AFIFO_AFULL));
    end
  end

endmodule

/* rtl/afifo_rd_ctrl.sv */
`timescale 1ns/1ns

`include "afifo_cfg.svh"

module afifo_rd_ctrl import afifo_pkg::*; (
  input  logic      rd_clk,
  input  logic      rd_rst_n,
  input  logic      rd_en,
  input  ptr_t      wr_ptr_sync,
  output logic      ram_rd_en,
  output addr_t     rd_addr,
  output ptr_t      rd_ptr_gray,
  output rd_flags_t rd_flags
);

  ptr_t rd_ptr;
  ptr_t rd_ptr_nxt;
  ptr_t rd_gray_nxt;
  ptr_t fill_nxt;
  logic rd_ok;

  // ------------------------------------------------------------
  // request qualification and next pointer.
  // ------------------------------------------------------------
  assign rd_ok       = rd_en & ~rd_flags.empty;  // reads while empty are ignored.
  assign rd_ptr_nxt  = rd_ptr + ptr_t'(rd_ok);
  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;

  // synchronized write pointer is old, so this never overstates the fill.
  assign fill_nxt = wr_ptr_sync - rd_ptr_nxt;

  assign ram_rd_en = rd_ok;
  assign rd_addr   = rd_ptr[`AFIFO_ADDR_WIDTH-1:0];

  // ------------------------------------------------------------
  // pointer registers.
  // ------------------------------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // ------------------------------------------------------------
  // flags, both set out of reset.
  // ------------------------------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_flags.empty  <= 1'b1;
      rd_flags.aempty <= 1'b1;
    end else begin
      rd_flags.empty  <= (fill_nxt == '0);
      rd_flags.aempty <= (fill_nxt <= ptr_t'(`AFIFO_AEMPTY));
    end
  end

endmodule

/* rtl/async_fifo.sv */
`timescale 1ns/1ns

module async_fifo import afifo_pkg::*; (
  // write domain.
  input  logic      wr_clk,
  input  logic      wr_rst_n,
  input  logic      wr_en,
  input  data_t     wr_data,
  output wr_flags_t wr_flags,
  // read domain.
  input  logic      rd_clk,
  input  logic      rd_rst_n,
  input  logic      rd_en,
  output data_t     rd_data,
  output rd_flags_t rd_flags
);

  logic  ram_wr_en;
  logic  ram_rd_en;
  addr_t wr_addr;
  addr_t rd_addr;
  ptr_t  wr_ptr_gray;   // write clock domain.
  ptr_t  rd_ptr_gray;   // read clock domain.
  ptr_t  wr_ptr_sync;   // write pointer seen in the read domain, binary.
  ptr_t  rd_ptr_sync;   // read pointer seen in the write domain, binary.

  // ------------------------------------------------------------
  // storage.
  // ------------------------------------------------------------
  afifo_ram i_ram (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  // ------------------------------------------------------------
  // write side.
  // ------------------------------------------------------------
  afifo_wr_ctrl i_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_sync (rd_ptr_sync),
    .ram_wr_en   (ram_wr_en),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_flags    (wr_flags)
  );

  afifo_ptr_sync i_rd_ptr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_ptr_gray),
    .bin_out (rd_ptr_sync)
  );

  // ------------------------------------------------------------
  // read side.
  // ------------------------------------------------------------
  afifo_rd_ctrl i_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .ram_rd_en   (ram_rd_en),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_flags    (rd_flags)
  );

  afifo_ptr_sync i_wr_ptr_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_ptr_gray),
    .bin_out (wr_ptr_sync)
  );

endmodule

/* sim/async_fifo_chk.sv */
`timescale 1ns/1ns

module async_fifo_chk import afifo_pkg::*; (
  input logic      wr_clk,
  input logic      wr_rst_n,
  input logic      wr_en,
  input wr_flags_t wr_flags,
  input ptr_t      wr_ptr_gray,
  input logic      rd_clk,
  input logic      rd_rst_n,
  input logic      rd_en,
  input rd_flags_t rd_flags,
  input ptr_t      rd_ptr_gray
);

  int wr_fail_cnt = 0;  // failures seen on wr_clk.
  int rd_fail_cnt = 0;  // failures seen on rd_clk.

  // ------------------------------------------------------------
  // write domain.
  // ------------------------------------------------------------
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1)
    else begin
      wr_fail_cnt++;
      $error("wr_ptr_gray moved by more than one bit.");
    end

  wr_full_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_flags.full |-> wr_flags.afull)
    else begin
      wr_fail_cnt++;
      $error("full set without afull.");
    end

  wr_hold_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    (wr_flags.full && wr_en) |=> $stable(wr_ptr_gray))
    else begin
      wr_fail_cnt++;
      $error("write pointer moved while full.");
    end

  // ------------------------------------------------------------
  // read domain.
  // ------------------------------------------------------------
  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1)
    else begin
      rd_fail_cnt++;
      $error("rd_ptr_gray moved by more than one bit.");
    end

  rd_empty_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_flags.empty |-> rd_flags.aempty)
    else begin
      rd_fail_cnt++;
      $error("empty set without aempty.");
    end

  rd_hold_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    (rd_flags.empty && rd_en) |=> $stable(rd_ptr_gray))
    else begin
      rd_fail_cnt++;
      $error("read pointer moved while empty.");
    end

endmodule

/* sim/async_fifo_tb.sv */
`timescale 1ns/1ns

`include "afifo_cfg.svh"

module async_fifo_tb import afifo_pkg::*; ();

  localparam int WR_PERIOD = 4;
  localparam int RD_PERIOD = 7;
  localparam int CLK_RATIO = (RD_PERIOD + WR_PERIOD - 1) / WR_PERIOD;
  localparam int N_TRAFFIC = 400;
  localparam int TOTAL_OPS = 2 * N_TRAFFIC + 8 * `AFIFO_DEPTH;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS * CLK_RATIO + 200;

  logic      wr_clk = 1'b0;
  logic      rd_clk = 1'b0;
  logic      wr_rst_n;
  logic      rd_rst_n;
  logic      wr_en;
  logic      rd_en;
  data_t     wr_data;
  data_t     rd_data;
  wr_flags_t wr_flags;
  rd_flags_t rd_flags;

  data_t model_q[$];   // words accepted but not yet read.
  int    push_cnt = 0;
  int    seed;
  bit    wr_done;
  int    data_errs = 0;
  int    flag_errs = 0;
  int    model_errs = 0;
  int    other_errs = 0;

  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

  always begin
    #3 rd_clk = 1'b1;
    #4 rd_clk = 1'b0;  // 7 ns period.
  end

  async_fifo i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .wr_flags (wr_flags),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_flags (rd_flags)
  );

  bind async_fifo async_fifo_chk i_chk (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .wr_flags    (wr_flags),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .rd_flags    (rd_flags),
    .rd_ptr_gray (rd_ptr_gray)
  );

  // ------------------------------------------------------------
  // compare tasks and reference flags.
  // ------------------------------------------------------------
  task automatic check_data(input data_t exp);
    if (rd_data !== exp) begin
      $display("[ERROR] rd_data expected 0x%h got 0x%h at %0t", exp, rd_data, $time);
      data_errs++;
    end
  endtask

  task automatic check_wr_flags(input wr_flags_t exp);
    if (wr_flags !== exp) begin
      $display("[ERROR] wr_flags expected 0x%h got 0x%h at %0t", exp, wr_flags, $time);
      flag_errs++;
    end
  endtask

  task automatic check_rd_flags(input rd_flags_t exp);
    if (rd_flags !== exp) begin
      $display("[ERROR] rd_flags expected 0x%h got 0x%h at %0t", exp, rd_flags, $time);
      flag_errs++;
    end
  endtask

  function automatic wr_flags_t model_wr_flags();
    wr_flags_t f;
    f.full  = (model_q.size() == `AFIFO_DEPTH);
    f.afull = (model_q.size() >= `AFIFO_AFULL);
    return f;
  endfunction

  function automatic rd_flags_t model_rd_flags();
    rd_flags_t f;
    f.empty  = (model_q.size() == 0);
    f.aempty = (model_q.size() <= `AFIFO_AEMPTY);
    return f;
  endfunction

  function automatic int rand_pct();
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % 100;
  endfunction

  // ------------------------------------------------------------
  // model.
  // ------------------------------------------------------------
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !wr_flags.full) begin
      model_q.push_back(wr_data);
      push_cnt++;
    end
  end

  // pops on accepted reads and checks that ignored reads leave rd_data alone.
  initial begin
    data_t exp_word;
    data_t last_word;
    logic  do_check;
    last_word = '0;
    @(posedge rd_rst_n);
    check_data(last_word);
    forever begin
      @(posedge rd_clk);
      do_check = 1'b0;
      if (rd_en && !rd_flags.empty) begin
        if (model_q.size() == 0) begin
          $display("error: read accepted while the model holds no data at %0t", $time);
          other_errs++;
        end else begin
          exp_word  = model_q.pop_front();
          last_word = exp_word;
          do_check  = 1'b1;
        end
      end else if (rd_en) begin
        exp_word = last_word;  // the last word read stays on rd_data.
        do_check = 1'b1;
      end
      if (do_check) begin
        @(negedge rd_clk);
        check_data(exp_word);
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus helpers.
  // ------------------------------------------------------------
  task automatic write_one();
    @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = data_t'($random(seed));
    @(negedge wr_clk);
    wr_en   = 1'b0;
  endtask

  task automatic read_one();
    @(negedge rd_clk);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  // long enough for both pointers to cross.
  task automatic settle();
    repeat (10) @(negedge rd_clk);
    @(negedge wr_clk);
  endtask

  task automatic check_model_flags();
    check_wr_flags(model_wr_flags());
    @(negedge rd_clk);
    check_rd_flags(model_rd_flags());
  endtask

  task automatic fill_to(input int level);
    while (model_q.size() < level) write_one();
    while (model_q.size() > level) read_one();
    settle();
  endtask

  task automatic run_traffic(input int n_writes, input int wr_pct, input int rd_pct);
    int target;
    target  = push_cnt + n_writes;
    wr_done = 1'b0;
    fork
      begin
        while (push_cnt < target) begin
          @(negedge wr_clk);
          wr_en   = (rand_pct() < wr_pct);
          wr_data = data_t'($random(seed));
        end
        wr_en   = 1'b0;
        wr_done = 1'b1;
      end
      begin
        while (!(wr_done && model_q.size() == 0)) begin
          @(negedge rd_clk);
          rd_en = (rand_pct() < rd_pct);
        end
        rd_en = 1'b0;
      end
    join
  endtask

  task automatic check_model_size(input int exp);
    if (model_q.size() != exp) begin
      $display("error: model holds %0d words where %0d were expected", model_q.size(), exp);
      model_errs++;
    end
  endtask

  task automatic report_and_finish();
    int total;
    total = data_errs + flag_errs + model_errs + other_errs
          + i_async_fifo.i_chk.wr_fail_cnt + i_async_fifo.i_chk.rd_fail_cnt;
    $display("data errors %0d, flag errors %0d, model errors %0d, other errors %0d, %s %0d",
             data_errs, flag_errs, model_errs, other_errs, "assertion failures",
             i_async_fifo.i_chk.wr_fail_cnt + i_async_fifo.i_chk.rd_fail_cnt);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge wr_clk);
    $display("error: run timed out after %0d wr_clk cycles", TIMEOUT_CYCLES);
    other_errs++;
    report_and_finish();
  end

  // ------------------------------------------------------------
  // test sequence.
  // ------------------------------------------------------------
  initial begin
    int wr_pct;
    int rd_pct;
    int levels[4];
    seed     = 26008;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    levels   = '{`AFIFO_AEMPTY, `AFIFO_AEMPTY + 1, `AFIFO_AFULL - 1, `AFIFO_AFULL};
    repeat (4) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    check_wr_flags(wr_flags_t'{full: 1'b0, afull: 1'b0});
    check_rd_flags(rd_flags_t'{empty: 1'b1, aempty: 1'b1});

    repeat (4) begin  // random concurrent traffic.
      wr_pct = 30 + rand_pct() * 60 / 100;
      rd_pct = 30 + rand_pct() * 60 / 100;
      run_traffic(N_TRAFFIC / 4, wr_pct, rd_pct);
    end
    settle();
    check_model_flags();

    foreach (levels[i]) begin
      fill_to(levels[i]);
      check_model_flags();
    end

    // fill with reads stopped, then push into a full fifo.
    @(negedge wr_clk);
    while (!wr_flags.full) begin
      wr_en   = 1'b1;
      wr_data = data_t'($random(seed));
      @(negedge wr_clk);
    end
    repeat (6) begin
      wr_en   = 1'b1;
      wr_data = data_t'($random(seed));
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
    settle();
    check_model_size(`AFIFO_DEPTH);
    check_wr_flags(wr_flags_t'{full: 1'b1, afull: 1'b1});

    // drain, then read while empty.
    while (model_q.size() > 0) read_one();
    settle();
    check_rd_flags(rd_flags_t'{empty: 1'b1, aempty: 1'b1});
    @(negedge rd_clk);
    repeat (4) begin
      rd_en = 1'b1;
      @(negedge rd_clk);
    end
    rd_en = 1'b0;
    settle();
    check_model_flags();

    report_and_finish();
  end

endmodule

/* flist.f */
+incdir+include
rtl/afifo_pkg.sv
rtl/afifo_ram.sv
rtl/afifo_ptr_sync.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_rd_ctrl.sv
rtl/async_fifo.sv
sim/async_fifo_chk.sv
sim/async_fifo_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= async_fifo_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_STR)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
